// File: Bender.yml
package:
  name: rf_top

sources:
  - verilog/rf_addr_pkg.sv
  - verilog/rf_data_pkg.sv
  - verilog/rf_decode.sv
  - verilog/accum_unit.sv
  - verilog/relu_unit.sv
  - verilog/scratch_ram.sv
  - verilog/rf_result.sv
  - verilog/rf_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/rf_top_checker.sv
      - test/rf_top_tb.sv

// File: rf_top.f
verilog/rf_addr_pkg.sv
verilog/rf_data_pkg.sv
verilog/rf_decode.sv
verilog/accum_unit.sv
verilog/relu_unit.sv
verilog/scratch_ram.sv
verilog/rf_result.sv
verilog/rf_top.sv
test/tb_clock.sv
test/rf_top_checker.sv
test/rf_top_tb.sv

// File: test/rf_top_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rf_top_checker (
    input wire                            clk,
    input wire                            reset,
    input wire                            rf_we,
    input wire                            rf_re,
    input wire [rf_addr_pkg::n_slots-1:0] acc_ld,
    input wire [rf_addr_pkg::n_slots-1:0] act_ld,
    input wire                            ram_we
);

    // number of failed assertions
    int unsigned fail_count = 0;

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset) !(rf_we && rf_re))
        else begin
            $error("rf_we and rf_re are high in the same cycle");
            fail_count++;
        end

    a_one_ld: assert property (@(posedge clk) disable iff (reset) $onehot0({acc_ld, act_ld}))
        else begin
            $error("more than one slot load pulse is high");
            fail_count++;
        end

    a_ram_we_no_ld: assert property (@(posedge clk) disable iff (reset)
                                     !(ram_we && (|{acc_ld, act_ld})))
        else begin
            $error("ram_we is high together with a slot load pulse");
            fail_count++;
        end

endmodule

// rf_decode has no clock, so the checker sits in rf_top on the decoder's output nets
bind rf_top rf_top_checker i_checker (
    .clk    (clk),
    .reset  (reset),
    .rf_we  (rf_we),
    .rf_re  (rf_re),
    .acc_ld (acc_ld),
    .act_ld (act_ld),
    .ram_we (ram_we)
);

`default_nettype wire

// File: test/rf_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rf_top_tb;

    localparam int n_lanes       = 8;
    localparam int lane_w        = rf_data_pkg::lane_w;
    localparam int vec_w         = n_lanes * lane_w;
    localparam int reset_timeout = 10;
    localparam int op_idle       = 0;
    localparam int op_wr         = 1;
    localparam int op_rd         = 2;

    typedef logic [vec_w-1:0] vec_t;

    // lanes 0 and 1 saturate after two adds
    localparam vec_t acc_base = 64'h7f80_40c0_0af6_7090;

    wire                clk;
    wire                reset;
    wire  [vec_w-1:0]   rf_q;
    rf_addr_pkg::addr_t rf_addr;
    vec_t               rf_d;
    logic               rf_we;
    logic               rf_re;

    // stimulus table, one row per cycle
    int    op_tab [$];
    int    addr_tab [$];
    vec_t  data_tab [$];
    string name_tab [$];

    // reference model of the slots, the RAM array and the held RAM output
    vec_t   acc_m [4];
    vec_t   act_m [4];
    vec_t   ram_m [256];
    vec_t   ram_q_m;
    integer seed;
    int     waited;

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    rf_top #(.n_lanes(n_lanes)) i_dut (
        .clk     (clk),
        .reset   (reset),
        .rf_addr (rf_addr),
        .rf_d    (rf_d),
        .rf_we   (rf_we),
        .rf_re   (rf_re),
        .rf_q    (rf_q)
    );

    task automatic add_row(input int op, input int addr, input vec_t d, input string name);
        op_tab.push_back(op);
        addr_tab.push_back(addr);
        data_tab.push_back(d);
        name_tab.push_back(name);
    endtask

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < n_lanes; i++)
            v[i*lane_w +: lane_w] = rf_data_pkg::lane_t'($random(seed));
        return v;
    endfunction

    // lane-wise signed sum clamped to the lane range, ReLU of b when relu is set
    function automatic vec_t lane_op(input vec_t a, input vec_t b, input bit relu);
        vec_t r;
        int   s;
        for (int i = 0; i < n_lanes; i++) begin
            s = $signed(a[i*lane_w +: lane_w]) + $signed(b[i*lane_w +: lane_w]);
            if (relu && s < 0)
                s = 0;
            if (s > rf_data_pkg::lane_max)
                s = rf_data_pkg::lane_max;
            else if (s < rf_data_pkg::lane_min)
                s = rf_data_pkg::lane_min;
            r[i*lane_w +: lane_w] = s[lane_w-1:0];
        end
        return r;
    endfunction

    // true when addr is one of the four windows starting at base
    function automatic bit in_win(input int addr, input int base);
        return addr >= base && addr < base + 4;
    endfunction

    task automatic model_step(input int op, input int addr, input vec_t d);
        if (op == op_wr && in_win(addr, 'h100))
            acc_m[addr % 4] = lane_op(acc_m[addr % 4], d, 1'b0);
        else if (op == op_wr && in_win(addr, 'h120))
            act_m[addr % 4] = lane_op('0, d, 1'b1);
        else if (op == op_wr)
            ram_m[addr % 256] = d;
        else if (op == op_rd && !in_win(addr, 'h108) && !in_win(addr, 'h128))
            ram_q_m = ram_m[addr % 256];
    endtask

    function automatic vec_t expected_q(input int addr);
        if (in_win(addr, 'h108))
            return acc_m[addr % 4];
        if (in_win(addr, 'h128))
            return act_m[addr % 4];
        return ram_q_m;
    endfunction

    task automatic check_vector(input string name, input vec_t exp, input vec_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "rf_q does not match the reference model");
        end
    endtask

    task automatic check_lane(input string name, input rf_data_pkg::lane_t exp,
                              input rf_data_pkg::lane_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected lane %0d, actual lane %0d", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "lane 0 does not match the reference model");
        end
    endtask

    task automatic check_row(input int r);
        vec_t exp;
        exp = expected_q(addr_tab[r]);
        // lane 0 is the lane driven into saturation
        if (op_tab[r] == op_rd && in_win(addr_tab[r], 'h108))
            check_lane(name_tab[r], exp[lane_w-1:0], rf_q[lane_w-1:0]);
        check_vector(name_tab[r], exp, rf_q);
    endtask

    initial begin
        seed    = 32'h5720;
        rf_addr = '0;
        rf_d    = '0;
        rf_we   = 1'b0;
        rf_re   = 1'b0;
        ram_q_m = '0;
        for (int s = 0; s < 4; s++) begin
            acc_m[s] = '0;
            act_m[s] = '0;
        end

        // after reset ram_q is zero and every Y window reads zero
        add_row(op_idle, 'h005, '0, "reset_ram_q");
        for (int s = 0; s < 4; s++) begin
            add_row(op_rd, 'h108 + s, '0, "reset_acc_y");
            add_row(op_rd, 'h128 + s, '0, "reset_act_y");
        end
        // RAM readback, 0x1f0 aliases to entry 0xf0 and 0x100 reads entry 0x00
        add_row(op_wr, 'h010, 64'h0123_4567_89ab_cdef, "ram_wr_010");
        add_row(op_wr, 'h000, 64'hdead_beef_0bad_f00d, "ram_wr_000");
        add_row(op_wr, 'h020, 64'h8070_6050_4030_2010, "ram_wr_020");
        add_row(op_wr, 'h1f0, 64'hfeed_face_cafe_babe, "ram_wr_1f0");
        add_row(op_wr, 'h041, rand_vec(), "ram_wr_rand");
        add_row(op_rd, 'h010, '0, "ram_rd_010");
        add_row(op_rd, 'h0f0, '0, "ram_rd_alias_0f0");
        add_row(op_rd, 'h1f0, '0, "ram_rd_1f0");
        add_row(op_rd, 'h041, '0, "ram_rd_rand");
        add_row(op_rd, 'h100, '0, "ram_rd_via_x_window");
        for (int s = 0; s < 4; s++) begin
            add_row(op_wr, 'h100 + s, acc_base ^ vec_t'(s), "acc_x");
            add_row(op_wr, 'h100 + s, acc_base ^ vec_t'(s), "acc_x");
            add_row(op_rd, 'h108 + s, '0, "acc_sat_y");
            add_row(op_wr, 'h100 + s, rand_vec(), "acc_x_rand");
            add_row(op_rd, 'h108 + s, '0, "acc_rand_y");
        end
        // all ReLU slots written before any readback
        for (int s = 0; s < 4; s++)
            add_row(op_wr, 'h120 + s, rand_vec(), "act_x");
        for (int s = 0; s < 4; s++)
            add_row(op_rd, 'h128 + s, '0, "act_relu_y");
        // ram_q holds across slot writes, slot writes leave entries 0x00 and 0x20 alone
        add_row(op_rd, 'h010, '0, "hold_rd_010");
        add_row(op_wr, 'h100, rand_vec(), "hold_after_acc_wr");
        add_row(op_wr, 'h120, rand_vec(), "hold_after_act_wr");
        add_row(op_idle, 'h0f0, '0, "hold_idle");
        add_row(op_rd, 'h000, '0, "ram_000_kept");
        add_row(op_rd, 'h020, '0, "ram_020_kept");
        add_row(op_rd, 'h108, '0, "acc_0_final");

        waited = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > reset_timeout) begin
                $display("reset was not released within %0d cycles", reset_timeout);
                $display("STATUS: FAIL");
                $fatal(1, "timeout waiting for reset release");
            end
        end

        // the previous row is checked just before the next one is driven
        for (int r = 0; r < op_tab.size(); r++) begin
            @(posedge clk);
            #1;
            if (r > 0)
                check_row(r - 1);
            #1;
            rf_addr = rf_addr_pkg::addr_t'(addr_tab[r]);
            rf_d    = data_tab[r];
            rf_we   = (op_tab[r] == op_wr);
            rf_re   = (op_tab[r] == op_rd);
            model_step(op_tab[r], addr_tab[r], data_tab[r]);
        end
        @(posedge clk);
        #1;
        check_row(op_tab.size() - 1);
        rf_we = 1'b0;
        rf_re = 1'b0;

        if (i_dut.i_checker.fail_count != 0) begin
            $display("decoder assertions failed %0d times", i_dut.i_checker.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "decoder assertion failures");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset spans the first rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/accum_unit.sv
`timescale 1ns/1ps
`default_nettype none

module accum_unit #(
    parameter int n_lanes = 8
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire                                    ld,
    input  wire  [n_lanes*rf_data_pkg::lane_w-1:0] x,
    output logic [n_lanes*rf_data_pkg::lane_w-1:0] y
);

    localparam int lane_w = rf_data_pkg::lane_w;

    logic [n_lanes*lane_w-1:0] acc;
    logic [n_lanes*lane_w-1:0] acc_next;

    for (genvar i = 0; i < n_lanes; i++) begin : g_lane
        rf_data_pkg::lane_t old_lane;
        rf_data_pkg::lane_t in_lane;
        // one extra bit so the sum cannot wrap
        logic signed [lane_w:0] sum;

        assign old_lane = acc[i*lane_w +: lane_w];
        assign in_lane  = x[i*lane_w +: lane_w];
        assign sum      = old_lane + in_lane;

        always_comb begin
            if (sum > rf_data_pkg::lane_max)
                acc_next[i*lane_w +: lane_w] = rf_data_pkg::lane_max;
            else if (sum < rf_data_pkg::lane_min)
                acc_next[i*lane_w +: lane_w] = rf_data_pkg::lane_min;
            else
                acc_next[i*lane_w +: lane_w] = sum[lane_w-1:0];
        end
    end

    // accumulators only clear on reset
    always_ff @(posedge clk) begin
        if (reset)
            acc <= '0;
        else if (ld)
            acc <= acc_next;
    end

    assign y = acc;

endmodule

`default_nettype wire

// File: verilog/relu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module relu_unit #(
    parameter int n_lanes = 8
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire                                    ld,
    input  wire  [n_lanes*rf_data_pkg::lane_w-1:0] x,
    output logic [n_lanes*rf_data_pkg::lane_w-1:0] y
);

    localparam int lane_w = rf_data_pkg::lane_w;

    logic [n_lanes*lane_w-1:0] relu;
    logic [n_lanes*lane_w-1:0] act;

    for (genvar i = 0; i < n_lanes; i++) begin : g_lane
        rf_data_pkg::lane_t in_lane;

        assign in_lane = x[i*lane_w +: lane_w];
        // negative lanes become zero
        assign relu[i*lane_w +: lane_w] = (in_lane < 0) ? '0 : in_lane;
    end

    always_ff @(posedge clk) begin
        if (reset)
            act <= '0;
        else if (ld)
            act <= relu;
    end

    assign y = act;

endmodule

`default_nettype wire

// File: verilog/rf_addr_pkg.sv
`default_nettype none

package rf_addr_pkg;

    // slots per kind, fixed by the memory map below
    localparam int n_slots = 4;

    typedef logic [8:0] addr_t;

    // windows in the 0x100 page, everything else aliases into the RAM
    typedef enum addr_t {
        ADDR_ACC_0_X = 9'h100,
        ADDR_ACC_1_X = 9'h101,
        ADDR_ACC_2_X = 9'h102,
        ADDR_ACC_3_X = 9'h103,
        ADDR_ACC_0_Y = 9'h108,
        ADDR_ACC_1_Y = 9'h109,
        ADDR_ACC_2_Y = 9'h10a,
        ADDR_ACC_3_Y = 9'h10b,
        ADDR_ACT_0_X = 9'h120,
        ADDR_ACT_1_X = 9'h121,
        ADDR_ACT_2_X = 9'h122,
        ADDR_ACT_3_X = 9'h123,
        ADDR_ACT_0_Y = 9'h128,
        ADDR_ACT_1_Y = 9'h129,
        ADDR_ACT_2_Y = 9'h12a,
        ADDR_ACT_3_Y = 9'h12b
    } addr_map_e;

endpackage

`default_nettype wire

// File: verilog/rf_data_pkg.sv
`default_nettype none

package rf_data_pkg;

    // bits per lane
    localparam int lane_w = 8;

    typedef logic signed [lane_w-1:0] lane_t;

    // saturation limits of a signed lane
    localparam lane_t lane_max = 8'sd127;
    localparam lane_t lane_min = -8'sd128;

    // scratch RAM has 256 entries
    typedef logic [7:0] ram_idx_t;

endpackage

`default_nettype wire

// File: verilog/rf_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rf_decode (
    input  wire rf_addr_pkg::addr_t        rf_addr,
    input  wire                            rf_we,
    input  wire                            rf_re,
    output logic [rf_addr_pkg::n_slots-1:0] acc_ld,
    output logic [rf_addr_pkg::n_slots-1:0] act_ld,
    output logic                           ram_we,
    output logic                           ram_re
);

    rf_addr_pkg::addr_map_e win;

    assign win = rf_addr_pkg::addr_map_e'(rf_addr);

    // writes: X windows pulse a slot, anything else goes to the RAM
    always_comb begin
        acc_ld = '0;
        act_ld = '0;
        ram_we = 1'b0;
        if (rf_we) begin
            case (win)
                rf_addr_pkg::ADDR_ACC_0_X: acc_ld[0] = 1'b1;
                rf_addr_pkg::ADDR_ACC_1_X: acc_ld[1] = 1'b1;
                rf_addr_pkg::ADDR_ACC_2_X: acc_ld[2] = 1'b1;
                rf_addr_pkg::ADDR_ACC_3_X: acc_ld[3] = 1'b1;
                rf_addr_pkg::ADDR_ACT_0_X: act_ld[0] = 1'b1;
                rf_addr_pkg::ADDR_ACT_1_X: act_ld[1] = 1'b1;
                rf_addr_pkg::ADDR_ACT_2_X: act_ld[2] = 1'b1;
                rf_addr_pkg::ADDR_ACT_3_X: act_ld[3] = 1'b1;
                default:                   ram_we = 1'b1;
            endcase
        end
    end

    // reads: Y windows are served from the slot outputs, no enable needed
    always_comb begin
        ram_re = 1'b0;
        if (rf_re) begin
            case (win)
                rf_addr_pkg::ADDR_ACC_0_Y,
                rf_addr_pkg::ADDR_ACC_1_Y,
                rf_addr_pkg::ADDR_ACC_2_Y,
                rf_addr_pkg::ADDR_ACC_3_Y,
                rf_addr_pkg::ADDR_ACT_0_Y,
                rf_addr_pkg::ADDR_ACT_1_Y,
                rf_addr_pkg::ADDR_ACT_2_Y,
                rf_addr_pkg::ADDR_ACT_3_Y: ram_re = 1'b0;
                default:                   ram_re = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/rf_result.sv
`timescale 1ns/1ps
`default_nettype none

module rf_result #(
    parameter int n_lanes = 8
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire  rf_addr_pkg::addr_t               rf_addr,
    input  wire  [n_lanes*rf_data_pkg::lane_w-1:0] acc_y [rf_addr_pkg::n_slots],
    input  wire  [n_lanes*rf_data_pkg::lane_w-1:0] act_y [rf_addr_pkg::n_slots],
    input  wire  [n_lanes*rf_data_pkg::lane_w-1:0] ram_q,
    output logic [n_lanes*rf_data_pkg::lane_w-1:0] rf_q
);

    // delayed by one cycle to line up with the RAM read
    rf_addr_pkg::addr_t addr_q;

    always_ff @(posedge clk) begin
        if (reset)
            addr_q <= '0;
        else
            addr_q <= rf_addr;
    end

    always_comb begin
        case (addr_q)
            rf_addr_pkg::ADDR_ACC_0_Y: rf_q = acc_y[0];
            rf_addr_pkg::ADDR_ACC_1_Y: rf_q = acc_y[1];
            rf_addr_pkg::ADDR_ACC_2_Y: rf_q = acc_y[2];
            rf_addr_pkg::ADDR_ACC_3_Y: rf_q = acc_y[3];
            rf_addr_pkg::ADDR_ACT_0_Y: rf_q = act_y[0];
            rf_addr_pkg::ADDR_ACT_1_Y: rf_q = act_y[1];
            rf_addr_pkg::ADDR_ACT_2_Y: rf_q = act_y[2];
            rf_addr_pkg::ADDR_ACT_3_Y: rf_q = act_y[3];
            // unmapped addresses read the RAM
            default:                   rf_q = ram_q;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rf_top.sv
`timescale 1ns/1ps
`default_nettype none

module rf_top #(
    parameter int n_lanes = 8
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire  rf_addr_pkg::addr_t               rf_addr,
    input  wire  [n_lanes*rf_data_pkg::lane_w-1:0] rf_d,
    input  wire                                    rf_we,
    input  wire                                    rf_re,
    output logic [n_lanes*rf_data_pkg::lane_w-1:0] rf_q
);

    localparam int vec_w = n_lanes * rf_data_pkg::lane_w;

    logic [rf_addr_pkg::n_slots-1:0] acc_ld;
    logic [rf_addr_pkg::n_slots-1:0] act_ld;
    logic                            ram_we;
    logic                            ram_re;
    logic [vec_w-1:0]                acc_y [rf_addr_pkg::n_slots];
    logic [vec_w-1:0]                act_y [rf_addr_pkg::n_slots];
    logic [vec_w-1:0]                ram_q;
    rf_data_pkg::ram_idx_t           ram_idx;

    // RAM sees the low byte of every address
    assign ram_idx = rf_addr[7:0];

    rf_decode i_decode (
        .rf_addr (rf_addr),
        .rf_we   (rf_we),
        .rf_re   (rf_re),
        .acc_ld  (acc_ld),
        .act_ld  (act_ld),
        .ram_we  (ram_we),
        .ram_re  (ram_re)
    );

    for (genvar s = 0; s < rf_addr_pkg::n_slots; s++) begin : g_slot
        accum_unit #(.n_lanes(n_lanes)) i_accum (
            .clk   (clk),
            .reset (reset),
            .ld    (acc_ld[s]),
            .x     (rf_d),
            .y     (acc_y[s])
        );

        relu_unit #(.n_lanes(n_lanes)) i_relu (
            .clk   (clk),
            .reset (reset),
            .ld    (act_ld[s]),
            .x     (rf_d),
            .y     (act_y[s])
        );
    end

    scratch_ram #(.n_lanes(n_lanes)) i_ram (
        .clk   (clk),
        .reset (reset),
        .we    (ram_we),
        .re    (ram_re),
        .idx   (ram_idx),
        .d     (rf_d),
        .q     (ram_q)
    );

    rf_result #(.n_lanes(n_lanes)) i_result (
        .clk     (clk),
        .reset   (reset),
        .rf_addr (rf_addr),
        .acc_y   (acc_y),
        .act_y   (act_y),
        .ram_q   (ram_q),
        .rf_q    (rf_q)
    );

endmodule

`default_nettype wire

// File: verilog/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_ram #(
    parameter int n_lanes = 8
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire                                    we,
    input  wire                                    re,
    input  wire  rf_data_pkg::ram_idx_t            idx,
    input  wire  [n_lanes*rf_data_pkg::lane_w-1:0] d,
    output logic [n_lanes*rf_data_pkg::lane_w-1:0] q
);

    localparam int depth = 2 ** $bits(rf_data_pkg::ram_idx_t);

    logic [n_lanes*rf_data_pkg::lane_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we)
            mem[idx] <= d;
    end

    // q keeps the last read until the next re
    always_ff @(posedge clk) begin
        if (reset)
            q <= '0;
        else if (re)
            q <= mem[idx];
    end

endmodule

`default_nettype wire
